// File: common/bus_pkg.sv
package bus_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;
  localparam int STRB_W     = 4;

  // core-local timer, two 32-bit halves of mtime
  localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 32'h0200_BFFC;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_RD_ADDR = 3'd1,
    ST_RD_DATA = 3'd2,
    ST_WR_ADDR = 3'd3,
    ST_WR_DATA = 3'd4,
    ST_WR_RESP = 3'd5,
    ST_CLINT   = 3'd6
  } arb_state_e;

  // axsize encoding, bytes = 2**size
  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } axi_size_e;

  typedef enum logic [0:0] {
    SEL_IFU = 1'b0,
    SEL_LSU = 1'b1
  } port_sel_e;

  function automatic axi_size_e strb_to_size(input logic [STRB_W-1:0] strb);
    axi_size_e size;
    case (strb)
      4'b0001:
      begin
        size = SZ_BYTE;
      end
      4'b0011:
      begin
        size = SZ_HALF;
      end
      default:
      begin
        size = SZ_WORD; // full word and anything odd
      end
    endcase
    return size;
  endfunction

  function automatic logic is_clint_addr(input logic [ADDR_W-1:0] addr);
    return (addr == CLINT_MTIME_LO) || (addr == CLINT_MTIME_HI);
  endfunction

endpackage

// File: common/mem_port_if.sv
interface mem_port_if;

  logic [bus_pkg::ADDR_W-1:0] addr;
  logic                       rd;
  logic                       wr;
  logic [bus_pkg::STRB_W-1:0] strb;
  logic [bus_pkg::DATA_W-1:0] wdata;
  logic [bus_pkg::DATA_W-1:0] rdata;
  logic                       rvalid; // one-cycle pulse
  logic                       wdone;  // one-cycle pulse

  modport client (
    output addr,
    output rd,
    output wr,
    output strb,
    output wdata,
    input  rdata,
    input  rvalid,
    input  wdone
  );

  modport arbiter (
    input  addr,
    input  rd,
    input  wr,
    input  strb,
    input  wdata,
    output rdata,
    output rvalid,
    output wdone
  );

endinterface

// File: bus_arbiter/arbiter_ctrl.sv
module arbiter_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  mem_port_if.arbiter                ifu,
  mem_port_if.arbiter                lsu,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  input  logic                       m_bvalid_i,
  output logic                       m_bready_o,
  output logic [bus_pkg::ADDR_W-1:0] req_addr_o,
  output logic [bus_pkg::STRB_W-1:0] req_strb_o,
  output logic [bus_pkg::DATA_W-1:0] req_wdata_o,
  output bus_pkg::port_sel_e         sel_o,
  output bus_pkg::arb_state_e        state_o,
  output logic                       rd_done_o,
  output logic                       wr_done_o
);

  bus_pkg::arb_state_e        state_q;
  bus_pkg::port_sel_e         sel_q;
  logic                       clint_wait_q;
  logic                       rd_done_q;
  logic                       wr_done_q;
  logic                       lsu_req;
  logic                       ifu_req;
  logic                       grant;
  logic [bus_pkg::ADDR_W-1:0] pick_addr;
  logic [bus_pkg::STRB_W-1:0] pick_strb;
  logic [bus_pkg::DATA_W-1:0] pick_wdata;
  logic                       pick_wr;
  logic [bus_pkg::ADDR_W-1:0] addr_q;
  logic [bus_pkg::STRB_W-1:0] strb_q;
  logic [bus_pkg::DATA_W-1:0] wdata_q;

  // a port still sees its request high during its own done pulse
  always_comb
  begin
    lsu_req = (lsu.rd | lsu.wr) & ~wr_done_q
              & ~(rd_done_q & (sel_q == bus_pkg::SEL_LSU));
    ifu_req = (ifu.rd | ifu.wr) & ~(rd_done_q & (sel_q == bus_pkg::SEL_IFU));
    grant   = (state_q == bus_pkg::ST_IDLE) & (lsu_req | ifu_req);
    if (lsu_req)
    begin
      pick_addr  = lsu.addr;
      pick_strb  = lsu.strb;
      pick_wdata = lsu.wdata;
      pick_wr    = lsu.wr;
    end
    else
    begin
      pick_addr  = ifu.addr;
      pick_strb  = ifu.strb;
      pick_wdata = ifu.wdata;
      pick_wr    = ifu.wr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= bus_pkg::ST_IDLE;
      sel_q        <= bus_pkg::SEL_IFU;
      clint_wait_q <= 1'b0;
      rd_done_q    <= 1'b0;
      wr_done_q    <= 1'b0;
    end
    else
    begin
      rd_done_q <= 1'b0;
      wr_done_q <= 1'b0;
      case (state_q)
        bus_pkg::ST_IDLE:
        begin
          if (grant)
          begin
            sel_q <= lsu_req ? bus_pkg::SEL_LSU : bus_pkg::SEL_IFU; // lsu first
            if (pick_wr)
              state_q <= bus_pkg::ST_WR_ADDR;
            else if (bus_pkg::is_clint_addr(pick_addr))
              state_q <= bus_pkg::ST_CLINT;
            else
              state_q <= bus_pkg::ST_RD_ADDR;
          end
        end
        bus_pkg::ST_RD_ADDR:
        begin
          if (m_arready_i)
            state_q <= bus_pkg::ST_RD_DATA;
        end
        bus_pkg::ST_RD_DATA:
        begin
          if (m_rvalid_i)
          begin
            state_q   <= bus_pkg::ST_IDLE;
            rd_done_q <= 1'b1;
          end
        end
        bus_pkg::ST_WR_ADDR:
        begin
          if (m_awready_i)
            state_q <= bus_pkg::ST_WR_DATA;
        end
        bus_pkg::ST_WR_DATA:
        begin
          if (m_wready_i)
            state_q <= bus_pkg::ST_WR_RESP;
        end
        bus_pkg::ST_WR_RESP:
        begin
          if (m_bvalid_i)
          begin
            state_q   <= bus_pkg::ST_IDLE;
            wr_done_q <= 1'b1;
          end
        end
        bus_pkg::ST_CLINT:
        begin
          // timer answers in the second cycle, fixed
          clint_wait_q <= ~clint_wait_q;
          if (clint_wait_q)
          begin
            state_q   <= bus_pkg::ST_IDLE;
            rd_done_q <= 1'b1;
          end
        end
        default:
        begin
          state_q <= bus_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      addr_q  <= pick_addr;
      strb_q  <= pick_strb;
      wdata_q <= pick_wdata;
    end
  end

  assign m_arvalid_o = (state_q == bus_pkg::ST_RD_ADDR);
  assign m_rready_o  = (state_q == bus_pkg::ST_RD_DATA);
  assign m_awvalid_o = (state_q == bus_pkg::ST_WR_ADDR);
  assign m_wvalid_o  = (state_q == bus_pkg::ST_WR_DATA); // after aw accepted
  assign m_bready_o  = (state_q == bus_pkg::ST_WR_RESP);

  assign req_addr_o  = addr_q;
  assign req_strb_o  = strb_q;
  assign req_wdata_o = wdata_q;
  assign sel_o       = sel_q;
  assign state_o     = state_q;
  assign rd_done_o   = rd_done_q;
  assign wr_done_o   = wr_done_q;

  assign lsu.wdone = wr_done_q;
  assign ifu.wdone = 1'b0; // fetch never writes
endmodule

// File: bus_arbiter/read_lane_mux.sv
module read_lane_mux (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [bus_pkg::AXI_DATA_W-1:0] m_rdata_i,
  input  logic [bus_pkg::ADDR_W-1:0]     req_addr_i,
  input  bus_pkg::port_sel_e             sel_i,
  input  bus_pkg::arb_state_e            state_i,
  input  logic                           m_rvalid_i,
  input  logic                           m_rready_i,
  input  logic [bus_pkg::DATA_W-1:0]     clint_rdata_i,
  input  logic                           clint_rvalid_i,
  mem_port_if.arbiter                    ifu,
  mem_port_if.arbiter                    lsu
);

  logic                       capture;
  logic [bus_pkg::DATA_W-1:0] lane;
  logic [bus_pkg::DATA_W-1:0] rdata_q;
  logic                       rvalid_q;

  assign capture = (m_rvalid_i & m_rready_i) | clint_rvalid_i;

  always_comb
  begin
    if (state_i == bus_pkg::ST_CLINT)
      lane = clint_rdata_i;
    else if (req_addr_i[2])
      lane = m_rdata_i[63:32]; // upper word of the beat
    else
      lane = m_rdata_i[31:0];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= capture;
  end

  always_ff @(posedge clk)
  begin
    if (capture)
      rdata_q <= lane;
  end

  // sel still holds the grant during the pulse
  assign ifu.rdata  = rdata_q;
  assign ifu.rvalid = rvalid_q & (sel_i == bus_pkg::SEL_IFU);
  assign lsu.rdata  = rdata_q;
  assign lsu.rvalid = rvalid_q & (sel_i == bus_pkg::SEL_LSU);
endmodule

// File: bus_arbiter/write_lane_align.sv
module write_lane_align (
  input  logic [bus_pkg::ADDR_W-1:0]     req_addr_i,
  input  logic [bus_pkg::STRB_W-1:0]     req_strb_i,
  input  logic [bus_pkg::DATA_W-1:0]     req_wdata_i,
  output logic [bus_pkg::ADDR_W-1:0]     m_awaddr_o,
  output bus_pkg::axi_size_e             m_awsize_o,
  output logic [bus_pkg::AXI_DATA_W-1:0] m_wdata_o,
  output logic [7:0]                     m_wstrb_o,
  output logic [bus_pkg::ADDR_W-1:0]     m_araddr_o,
  output bus_pkg::axi_size_e             m_arsize_o
);

  logic [1:0]                 byte_off;
  logic [4:0]                 bit_off;
  logic [bus_pkg::DATA_W-1:0] lane_data;
  logic [bus_pkg::STRB_W-1:0] lane_strb;
  bus_pkg::axi_size_e         size;

  assign byte_off = req_addr_i[1:0];
  assign bit_off  = {byte_off, 3'b000};
  assign size     = bus_pkg::strb_to_size(req_strb_i);

  always_comb
  begin
    lane_data = req_wdata_i << bit_off;
    lane_strb = req_strb_i << byte_off;
  end

  // data goes to both halves, strobe picks the live one
  assign m_wdata_o = {lane_data, lane_data};

  always_comb
  begin
    if (req_addr_i[2])
      m_wstrb_o = {lane_strb, 4'b0000};
    else
      m_wstrb_o = {4'b0000, lane_strb};
  end

  assign m_awaddr_o = req_addr_i;
  assign m_araddr_o = req_addr_i;
  assign m_awsize_o = size;
  assign m_arsize_o = size; // fetch strobe is all ones, so word
endmodule

// File: design/clint_timer.sv
module clint_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_i,
  input  logic                       addr_hi_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output logic                       rvalid_o
);

  logic [63:0] mtime;
  logic        fire;

  // rd_i spans the whole timer state, answer only once
  assign fire = rd_i & ~rvalid_o;

  always_ff @(posedge clk)
  begin
    if (rst)
      mtime <= 64'd0;
    else
      mtime <= mtime + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_o <= 1'b0;
    else
      rvalid_o <= fire;
  end

  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      if (addr_hi_i)
        rdata_o <= mtime[63:32];
      else
        rdata_o <= mtime[31:0];
    end
  end
endmodule

// File: design/core_bus_top.sv
module core_bus_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [bus_pkg::ADDR_W-1:0]     ifu_addr_i,
  input  logic                           ifu_req_i,
  output logic [bus_pkg::DATA_W-1:0]     ifu_rdata_o,
  output logic                           ifu_rvalid_o,
  input  logic [bus_pkg::ADDR_W-1:0]     lsu_addr_i,
  input  logic                           lsu_rd_i,
  input  logic                           lsu_wr_i,
  input  logic [bus_pkg::STRB_W-1:0]     lsu_strb_i,
  input  logic [bus_pkg::DATA_W-1:0]     lsu_wdata_i,
  output logic [bus_pkg::DATA_W-1:0]     lsu_rdata_o,
  output logic                           lsu_rvalid_o,
  output logic                           lsu_wdone_o,
  output logic                           m_arvalid_o,
  input  logic                           m_arready_i,
  output logic [bus_pkg::ADDR_W-1:0]     m_araddr_o,
  output bus_pkg::axi_size_e             m_arsize_o,
  input  logic [bus_pkg::AXI_DATA_W-1:0] m_rdata_i,
  input  logic                           m_rvalid_i,
  output logic                           m_rready_o,
  output logic                           m_awvalid_o,
  input  logic                           m_awready_i,
  output logic [bus_pkg::ADDR_W-1:0]     m_awaddr_o,
  output bus_pkg::axi_size_e             m_awsize_o,
  output logic                           m_wvalid_o,
  input  logic                           m_wready_i,
  output logic [bus_pkg::AXI_DATA_W-1:0] m_wdata_o,
  output logic [7:0]                     m_wstrb_o,
  input  logic                           m_bvalid_i,
  output logic                           m_bready_o
);

  logic [bus_pkg::ADDR_W-1:0] req_addr;
  logic [bus_pkg::STRB_W-1:0] req_strb;
  logic [bus_pkg::DATA_W-1:0] req_wdata;
  bus_pkg::port_sel_e         sel;
  bus_pkg::arb_state_e        state;
  logic [bus_pkg::DATA_W-1:0] clint_rdata;
  logic                       clint_rvalid;

  mem_port_if ifu_port ();
  mem_port_if lsu_port ();

  // fetch side is read-only, whole word
  assign ifu_port.addr  = ifu_addr_i;
  assign ifu_port.rd    = ifu_req_i;
  assign ifu_port.wr    = 1'b0;
  assign ifu_port.strb  = '1;
  assign ifu_port.wdata = '0;

  assign lsu_port.addr  = lsu_addr_i;
  assign lsu_port.rd    = lsu_rd_i;
  assign lsu_port.wr    = lsu_wr_i;
  assign lsu_port.strb  = lsu_strb_i;
  assign lsu_port.wdata = lsu_wdata_i;

  assign ifu_rdata_o  = ifu_port.rdata;
  assign ifu_rvalid_o = ifu_port.rvalid;
  assign lsu_rdata_o  = lsu_port.rdata;
  assign lsu_rvalid_o = lsu_port.rvalid;
  assign lsu_wdone_o  = lsu_port.wdone;

  arbiter_ctrl arbiter_ctrl_inst (
    .clk         (clk),
    .rst         (rst),
    .ifu         (ifu_port.arbiter),
    .lsu         (lsu_port.arbiter),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o),
    .req_addr_o  (req_addr),
    .req_strb_o  (req_strb),
    .req_wdata_o (req_wdata),
    .sel_o       (sel),
    .state_o     (state),
    .rd_done_o   (),
    .wr_done_o   ()
  );

  read_lane_mux read_lane_mux_inst (
    .clk            (clk),
    .rst            (rst),
    .m_rdata_i      (m_rdata_i),
    .req_addr_i     (req_addr),
    .sel_i          (sel),
    .state_i        (state),
    .m_rvalid_i     (m_rvalid_i),
    .m_rready_i     (m_rready_o),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .ifu            (ifu_port.arbiter),
    .lsu            (lsu_port.arbiter)
  );

  write_lane_align write_lane_align_inst (
    .req_addr_i  (req_addr),
    .req_strb_i  (req_strb),
    .req_wdata_i (req_wdata),
    .m_awaddr_o  (m_awaddr_o),
    .m_awsize_o  (m_awsize_o),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_araddr_o  (m_araddr_o),
    .m_arsize_o  (m_arsize_o)
  );

  clint_timer clint_timer_inst (
    .clk       (clk),
    .rst       (rst),
    .rd_i      (state == bus_pkg::ST_CLINT),
    .addr_hi_i (req_addr == bus_pkg::CLINT_MTIME_HI),
    .rdata_o   (clint_rdata),
    .rvalid_o  (clint_rvalid)
  );
endmodule

// File: bench/axi_slave_model.sv
module axi_slave_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        arvalid_i,
  output logic        arready_o,
  input  logic [31:0] araddr_i,
  output logic [63:0] rdata_o,
  output logic        rvalid_o,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] awaddr_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  output logic        bvalid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PH_IDLE  = 0;
  localparam int PH_RDATA = 1;
  localparam int PH_WDATA = 2;
  localparam int PH_BRESP = 3;

  logic [63:0] mem [logic [28:0]]; // sparse, indexed by 64-bit word
  logic [31:0] rng_state = 32'd22306;
  logic [31:0] addr_q;
  int          phase;
  int          wait_cnt;

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
  endfunction

  // 0 to 3 cycles of stall
  function int next_delay();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'(rng_state[17:16]);
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] a);
    logic [63:0] w;
    if (mem.exists(a[31:3]))
      return mem[a[31:3]];
    for (int i = 0; i < 8; i++)
      w[8*i +: 8] = fill_byte({a[31:3], 3'b000} + i);
    return w;
  endfunction

  task automatic write_beat(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
    logic [63:0] w;
    w = read_word(a);
    for (int i = 0; i < 8; i++)
      if (s[i])
        w[8*i +: 8] = d[8*i +: 8];
    mem[a[31:3]] = w;
  endtask

  // everything moves on the falling edge, the DUT samples on the rising one
  always @(negedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rdata_o   <= '0;
      phase     = PH_IDLE;
      wait_cnt  = next_delay();
    end
    else
    begin
      arready_o <= 1'b0; // all handshakes are one-cycle pulses
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      case (phase)
        PH_IDLE:
        begin
          if (arvalid_i || awvalid_i)
          begin
            if (wait_cnt > 0)
              wait_cnt--;
            else if (arvalid_i)
            begin
              arready_o <= 1'b1;
              addr_q    = araddr_i;
              phase     = PH_RDATA;
              wait_cnt  = next_delay();
            end
            else
            begin
              awready_o <= 1'b1;
              addr_q    = awaddr_i;
              phase     = PH_WDATA;
              wait_cnt  = next_delay();
            end
          end
        end
        PH_RDATA:
        begin
          if (wait_cnt > 0)
            wait_cnt--;
          else
          begin
            rvalid_o <= 1'b1; // rready is up in the data state
            rdata_o  <= read_word(addr_q);
            phase    = PH_IDLE;
            wait_cnt = next_delay();
          end
        end
        PH_WDATA:
        begin
          if (wvalid_i && wait_cnt > 0)
            wait_cnt--;
          else if (wvalid_i)
          begin
            wready_o <= 1'b1;
            write_beat(addr_q, wdata_i, wstrb_i);
            phase    = PH_BRESP;
            wait_cnt = next_delay();
          end
        end
        default:
        begin
          if (wait_cnt > 0)
            wait_cnt--;
          else
          begin
            bvalid_o <= 1'b1;
            phase    = PH_IDLE;
            wait_cnt = next_delay();
          end
        end
      endcase
    end
  end
endmodule

// File: bench/core_bus_tb.sv
module core_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 4;
  localparam int N_FETCH    = 8;
  localparam int N_STORE    = 24;
  localparam int N_PAIR     = 4;
  localparam int N_TIMER    = 6;
  localparam int N_MIX      = 150;
  localparam int TXN_TOTAL  = N_FETCH + 2 * N_STORE + 2 * N_PAIR + N_TIMER + N_MIX;
  localparam logic [31:0] MEM_BASE = 32'h8000_0000;

  logic                           clk = 1'b0;
  logic                           rst;
  logic [bus_pkg::ADDR_W-1:0]     ifu_addr_i;
  logic                           ifu_req_i;
  logic [bus_pkg::DATA_W-1:0]     ifu_rdata_o;
  logic                           ifu_rvalid_o;
  logic [bus_pkg::ADDR_W-1:0]     lsu_addr_i;
  logic                           lsu_rd_i;
  logic                           lsu_wr_i;
  logic [bus_pkg::STRB_W-1:0]     lsu_strb_i;
  logic [bus_pkg::DATA_W-1:0]     lsu_wdata_i;
  logic [bus_pkg::DATA_W-1:0]     lsu_rdata_o;
  logic                           lsu_rvalid_o;
  logic                           lsu_wdone_o;
  logic                           m_arvalid_o;
  logic                           m_arready_i;
  logic [bus_pkg::ADDR_W-1:0]     m_araddr_o;
  bus_pkg::axi_size_e             m_arsize_o;
  logic [bus_pkg::AXI_DATA_W-1:0] m_rdata_i;
  logic                           m_rvalid_i;
  logic                           m_rready_o;
  logic                           m_awvalid_o;
  logic                           m_awready_i;
  logic [bus_pkg::ADDR_W-1:0]     m_awaddr_o;
  bus_pkg::axi_size_e             m_awsize_o;
  logic                           m_wvalid_o;
  logic                           m_wready_i;
  logic [bus_pkg::AXI_DATA_W-1:0] m_wdata_o;
  logic [7:0]                     m_wstrb_o;
  logic                           m_bvalid_i;
  logic                           m_bready_o;

  logic [7:0]  model_mem [logic [31:0]];
  logic [31:0] rng_state = 32'd22306;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [3:0]  wr_strb;
  logic [31:0] wr_data;
  logic [31:0] last_lo;
  logic        timer_active;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;

  always #(CLK_PERIOD / 2) clk = ~clk;

  core_bus_top core_bus_top_inst (.*);

  axi_slave_model axi_slave_model_inst (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (m_arvalid_o),
    .arready_o (m_arready_i),
    .araddr_i  (m_araddr_o),
    .rdata_o   (m_rdata_i),
    .rvalid_o  (m_rvalid_i),
    .awvalid_i (m_awvalid_o),
    .awready_o (m_awready_i),
    .awaddr_i  (m_awaddr_o),
    .wvalid_i  (m_wvalid_o),
    .wready_o  (m_wready_i),
    .wdata_i   (m_wdata_o),
    .wstrb_i   (m_wstrb_o),
    .bvalid_o  (m_bvalid_i)
  );

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {rng_state[30:16], rng_state[15:0] ^ rng_state[31:16]};
  endfunction

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    logic [31:0] w;
    logic [31:0] b;
    for (int i = 0; i < 4; i++)
    begin
      b = {a[31:2], 2'b00} + i;
      w[8*i +: 8] = model_mem.exists(b) ? model_mem[b] : fill_byte(b);
    end
    return w;
  endfunction

  // size follows the number of enabled bytes
  function automatic bus_pkg::axi_size_e size_of_strb(input logic [3:0] s);
    int ones;
    ones = s[0] + s[1] + s[2] + s[3];
    if (ones == 1)
      return bus_pkg::SZ_BYTE;
    else if (ones == 2 && s == 4'b0011)
      return bus_pkg::SZ_HALF;
    return bus_pkg::SZ_WORD;
  endfunction

  function automatic logic [7:0] expect_wstrb(input logic [31:0] a, input logic [3:0] s);
    return {4'b0000, s} << a[2:0];
  endfunction

  // byte j of each half carries data byte j - offset, zero below the offset
  function automatic logic [63:0] expect_wdata(input logic [31:0] a, input logic [31:0] d);
    logic [63:0] beat;
    int          src;
    beat = '0;
    for (int i = 0; i < 8; i++)
    begin
      src = (i % 4) - int'(a[1:0]);
      if (src >= 0)
        beat[8*i +: 8] = d[8*src +: 8];
    end
    return beat;
  endfunction

  task automatic check_word(input string name, input logic [bus_pkg::DATA_W-1:0] exp_v,
                            input logic [bus_pkg::DATA_W-1:0] got_v);
    check_cnt++;
    if (got_v !== exp_v)
    begin
      err_cnt++;
      $display("[FAIL] %s expected %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic check_addr(input string name, input logic [bus_pkg::ADDR_W-1:0] exp_v,
                            input logic [bus_pkg::ADDR_W-1:0] got_v);
    check_cnt++;
    if (got_v !== exp_v)
    begin
      err_cnt++;
      $display("[FAIL] %s expected %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic check_size(input string name, input bus_pkg::axi_size_e exp_v,
                            input bus_pkg::axi_size_e got_v);
    check_cnt++;
    if (got_v !== exp_v)
    begin
      err_cnt++;
      $display("[FAIL] %s expected %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic check_strb(input string name, input logic [7:0] exp_v, input logic [7:0] got_v);
    check_cnt++;
    if (got_v !== exp_v)
    begin
      err_cnt++;
      $display("[FAIL] %s expected %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic check_beat(input string name, input logic [63:0] exp_v, input logic [63:0] got_v);
    check_cnt++;
    if (got_v !== exp_v)
    begin
      err_cnt++;
      $display("[FAIL] %s expected %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic got_v);
    check_cnt++;
    if (got_v !== exp_v)
    begin
      err_cnt++;
      $display("[FAIL] %s expected %h got %h", name, exp_v, got_v);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("error: %s", what);
  endtask

  task automatic close_test(input string name, input int start_err);
    test_cnt++;
    $display("test %s done with %0d errors", name, err_cnt - start_err);
  endtask

  // AXI payload watch, sampled away from the rising edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (m_arvalid_o)
      begin
        check_size("m_arsize_o", bus_pkg::SZ_WORD, m_arsize_o);
        check_addr("m_araddr_o", rd_addr, m_araddr_o);
        if (timer_active)
          report_error("an AXI read went out for a timer address");
      end
      if (m_awvalid_o)
      begin
        check_size("m_awsize_o", size_of_strb(wr_strb), m_awsize_o);
        check_addr("m_awaddr_o", wr_addr, m_awaddr_o);
      end
      if (m_wvalid_o)
      begin
        check_strb("m_wstrb_o", expect_wstrb(wr_addr, wr_strb), m_wstrb_o);
        check_beat("m_wdata_o", expect_wdata(wr_addr, wr_data), m_wdata_o);
      end
    end
  end

  task automatic fetch_word(input logic [31:0] addr);
    logic [31:0] expected;
    expected   = model_word(addr);
    rd_addr    = addr;
    ifu_addr_i = addr;
    ifu_req_i  = 1'b1;
    @(negedge clk);
    while (!ifu_rvalid_o)
      @(negedge clk);
    ifu_req_i = 1'b0;
    check_word("ifu_rdata_o", expected, ifu_rdata_o);
  endtask

  task automatic load_word(input logic [31:0] addr);
    logic [31:0] expected;
    expected   = model_word(addr);
    rd_addr    = addr;
    lsu_addr_i = addr;
    lsu_strb_i = 4'hF;
    lsu_rd_i   = 1'b1;
    @(negedge clk);
    while (!lsu_rvalid_o)
      @(negedge clk);
    lsu_rd_i = 1'b0;
    check_word("lsu_rdata_o", expected, lsu_rdata_o);
  endtask

  task automatic store_data(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
    logic [31:0] lane;
    logic [3:0]  lstrb;
    wr_addr     = addr;
    wr_strb     = strb;
    wr_data     = data;
    lsu_addr_i  = addr;
    lsu_strb_i  = strb;
    lsu_wdata_i = data;
    lsu_wr_i    = 1'b1;
    @(negedge clk);
    while (!lsu_wdone_o)
      @(negedge clk);
    lsu_wr_i = 1'b0;
    lane  = data << (8 * addr[1:0]);
    lstrb = strb << addr[1:0];
    for (int i = 0; i < 4; i++)
      if (lstrb[i])
        model_mem[{addr[31:2], 2'b00} + i] = lane[8*i +: 8];
  endtask

  // aligned byte, half or word somewhere in a 256-byte window
  task automatic random_store(output logic [31:0] addr);
    logic [31:0] r;
    logic [3:0]  strb;
    logic [1:0]  off;
    r = next_rand();
    case (r[1:0])
      2'd0:
      begin
        strb = 4'b0001;
        off  = r[3:2];
      end
      2'd1:
      begin
        strb = 4'b0011;
        off  = {r[2], 1'b0};
      end
      default:
      begin
        strb = 4'b1111;
        off  = 2'd0;
      end
    endcase
    addr = MEM_BASE | {r[11:6], off};
    store_data(addr, strb, next_rand());
  endtask

  task automatic timer_read(input logic hi);
    int cycles;
    @(negedge clk); // previous done pulse is over, arbiter idle
    timer_active = 1'b1;
    lsu_addr_i   = hi ? bus_pkg::CLINT_MTIME_HI : bus_pkg::CLINT_MTIME_LO;
    lsu_strb_i   = 4'hF;
    lsu_rd_i     = 1'b1;
    cycles       = 0;
    @(negedge clk);
    cycles++;
    while (!lsu_rvalid_o)
    begin
      @(negedge clk);
      cycles++;
    end
    lsu_rd_i     = 1'b0;
    timer_active = 1'b0;
    if (cycles != 3)
      report_error($sformatf("timer response took %0d cycles instead of 3", cycles));
    if (hi)
      check_word("lsu_rdata_o", 32'h0, lsu_rdata_o);
    else
    begin
      if (lsu_rdata_o <= last_lo)
        report_error("timer low half did not increase");
      last_lo = lsu_rdata_o;
    end
  endtask

  task automatic paired_read(input logic [31:0] load_addr, input logic [31:0] fetch_addr);
    logic [31:0] load_exp;
    logic [31:0] fetch_exp;
    int          cyc;
    int          lsu_at;
    int          ifu_at;
    @(negedge clk); // both raised from a clean idle
    load_exp   = model_word(load_addr);
    fetch_exp  = model_word(fetch_addr);
    rd_addr    = load_addr;
    lsu_addr_i = load_addr;
    lsu_strb_i = 4'hF;
    lsu_rd_i   = 1'b1;
    ifu_addr_i = fetch_addr;
    ifu_req_i  = 1'b1;
    cyc        = 0;
    lsu_at     = 0;
    ifu_at     = 0;
    while (lsu_at == 0 || ifu_at == 0)
    begin
      @(negedge clk);
      cyc++;
      if (lsu_rvalid_o && lsu_at == 0)
      begin
        lsu_at   = cyc;
        lsu_rd_i = 1'b0;
        rd_addr  = fetch_addr;
        check_word("lsu_rdata_o", load_exp, lsu_rdata_o);
      end
      if (ifu_rvalid_o && ifu_at == 0)
      begin
        ifu_at    = cyc;
        ifu_req_i = 1'b0;
        check_word("ifu_rdata_o", fetch_exp, ifu_rdata_o);
      end
    end
    if (lsu_at >= ifu_at)
      report_error("fetch was answered before the load raised with it");
  endtask

  initial
  begin
    #(300 * TXN_TOTAL * CLK_PERIOD);
    $display("watchdog expired, transactions did not complete in time");
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    logic [31:0] a;
    logic [31:0] r;
    int          start;
    rst          = 1'b1;
    ifu_addr_i   = '0;
    ifu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_rd_i     = 1'b0;
    lsu_wr_i     = 1'b0;
    lsu_strb_i   = '0;
    lsu_wdata_i  = '0;
    rd_addr      = '0;
    wr_addr      = '0;
    wr_strb      = '0;
    wr_data      = '0;
    last_lo      = '0;
    timer_active = 1'b0;
    err_cnt      = 0;
    check_cnt    = 0;
    test_cnt     = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    start = err_cnt;
    @(negedge clk);
    check_flag("m_arvalid_o", 1'b0, m_arvalid_o);
    check_flag("m_awvalid_o", 1'b0, m_awvalid_o);
    check_flag("m_wvalid_o", 1'b0, m_wvalid_o);
    check_flag("m_rready_o", 1'b0, m_rready_o);
    check_flag("m_bready_o", 1'b0, m_bready_o);
    close_test("reset_idle", start);

    start = err_cnt;
    for (int i = 0; i < N_FETCH; i++)
      fetch_word(MEM_BASE + 4 * i); // walks both lanes
    close_test("fetch_lanes", start);

    start = err_cnt;
    for (int i = 0; i < N_STORE; i++)
    begin
      random_store(a);
      load_word(a);
    end
    close_test("store_align", start);

    start = err_cnt;
    for (int i = 0; i < N_PAIR; i++)
    begin
      r = next_rand();
      paired_read(MEM_BASE | {r[7:2], 2'b00}, MEM_BASE | {r[15:10], 2'b00});
    end
    close_test("fetch_load_order", start);

    start = err_cnt;
    for (int i = 0; i < N_TIMER; i++)
      timer_read(i[0]);
    close_test("timer_read", start);

    start = err_cnt;
    for (int i = 0; i < N_MIX; i++)
    begin
      r = next_rand();
      case (r[1:0])
        2'd0: fetch_word(MEM_BASE | {r[9:4], 2'b00});
        2'd1: load_word(MEM_BASE | {r[9:4], 2'b00});
        2'd2: random_store(a);
        default: timer_read(1'b0);
      endcase
    end
    close_test("random_mix", start);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end
endmodule

// File: project.f
common/bus_pkg.sv
common/mem_port_if.sv
bus_arbiter/arbiter_ctrl.sv
bus_arbiter/read_lane_mux.sv
bus_arbiter/write_lane_align.sv
design/clint_timer.sv
design/core_bus_top.sv
bench/axi_slave_model.sv
bench/core_bus_tb.sv
